//--- sources.f
ctx_pkg.sv
ctx_cfg_regs.sv
context_manage.sv
ctx_frontend_top.sv
ctx_frontend_assert.sv
tb_ctx_frontend.sv

//--- tb_ctx_frontend.sv
`timescale 1ns/1ns

module tb_ctx_frontend;
    import ctx_pkg::*;

    localparam int num_phases = 2;
    localparam int traffic_cycles = 300;

    logic clk, rst_n, cfg_valid, cfg_ready, fetch_valid, fetch_ready;
    cfg_addr_t cfg_addr;
    word_t cfg_wdata, fetch_pc, dec_next_pc, dec_next_pc_f, ex_next_pc;
    ctx_mask_t fetch_ctx, dec_ctx, dec_ctx_t, dec_ctx_f, ex_jump_ctx, ex_branch_ctx;
    ctx_mask_t ex_hazard_ctx, ex_safe_ctx, hazard_info;
    logic dec_valid, dec_branch, ex_jump_valid, ex_branch_valid, ex_hazard;

    // reference model of the context table
    ctx_mask_t m_anc [num_ctx];
    ctx_mask_t m_hot, m_last, m_pend;

    ctx_frontend_top #(.num_contexts(num_ctx)) i_ctx_frontend_top (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        #(400 * num_phases * 8);
        $display("watchdog expired before the tests finished");
        $display("Test failed");
        $fatal(1);
    end

    always @(negedge clk) begin
        if (i_ctx_frontend_top.i_frontend_assert.fail_cnt != 0) begin
            $display("Test failed");
            $fatal(1);
        end
    end

    function automatic ctx_mask_t rot_left(input ctx_mask_t m, input int n);
        return (m << n) | (m >> (num_ctx - n));
    endfunction

    task automatic fail_value(input string name, input ctx_mask_t got, input ctx_mask_t exp);
        $display("Error %s got %h expected %h", name, got, exp);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic write_cfg(input cfg_addr_t addr, input word_t data);
        @(posedge clk);
        cfg_valid <= 1'b1;
        cfg_addr  <= addr;
        cfg_wdata <= data;
        do @(posedge clk); while (!cfg_ready);
        cfg_valid <= 1'b0;
    endtask

    task automatic clear_events();
        dec_valid <= 1'b0;
        dec_branch <= 1'b0;
        ex_jump_valid <= 1'b0;
        ex_branch_valid <= 1'b0;
        ex_hazard <= 1'b0;
    endtask

    // one event per cycle, legal for the model state
    task automatic drive_random();
        int r;
        int h;
        int s;
        ctx_mask_t info;
        clear_events();
        fetch_ready <= 1'($urandom_range(0, 1));
        r = $urandom_range(0, 9);
        dec_next_pc <= $urandom;
        dec_next_pc_f <= $urandom;
        ex_next_pc <= $urandom;
        if (r < 3 || r == 3) begin
            dec_valid <= 1'b1;
            dec_branch <= (r == 3);
            dec_ctx <= m_hot;
        end else if (r == 4) begin
            ex_branch_valid <= 1'b1;
            ex_branch_ctx <= ctx_mask_t'(1) << $urandom_range(0, num_ctx - 1);
        end else if (r == 5) begin
            h = $urandom_range(0, num_ctx - 1);
            info = m_anc[h];
            if (info[h]) begin
                for (int k = 0; k < num_ctx; k++) begin
                    s = (h + 1 + k) % num_ctx;
                    if ((m_anc[s] & info) == '0) begin
                        ex_hazard <= 1'b1;
                        ex_hazard_ctx <= ctx_mask_t'(1) << h;
                        ex_safe_ctx <= ctx_mask_t'(1) << s;
                        // now and then a jump into the path being squashed
                        if ($urandom_range(0, 1) == 1) begin
                            ex_jump_valid <= 1'b1;
                            ex_jump_ctx <= ctx_mask_t'(1) << h;
                        end
                        break;
                    end
                end
            end
        end else if (r == 6) begin
            ex_jump_valid <= 1'b1;
            ex_jump_ctx <= rot_left(m_hot, $urandom_range(1, num_ctx - 1));
        end
    endtask

    task automatic check_and_update();
        ctx_mask_t info;
        ctx_mask_t sq;
        ctx_mask_t pa;
        ctx_mask_t t;
        ctx_mask_t f;
        logic      exp_valid;
        sq = '0;
        t = rot_left(m_last, 1);
        f = rot_left(m_last, 2);
        if (dec_ctx_t != t) fail_value("dec_ctx_t", dec_ctx_t, t);
        if (dec_ctx_f != f) fail_value("dec_ctx_f", dec_ctx_f, f);
        if (ex_hazard) begin
            info = m_anc[$clog2(ex_hazard_ctx)];
            if (hazard_info != info) fail_value("hazard_info", hazard_info, info);
            if ((m_anc[$clog2(m_hot)] & info) != '0) m_hot = ex_safe_ctx;
            for (int i = 0; i < num_ctx; i++) begin
                if ((m_anc[i] & info) != '0) begin
                    m_anc[i] = '0;
                    sq[i] = 1'b1;
                end
            end
            m_pend &= ~sq;
        end
        if (ex_branch_valid) begin
            for (int i = 0; i < num_ctx; i++) m_anc[i] &= ~ex_branch_ctx;
        end
        if (dec_valid && !dec_branch) m_pend |= dec_ctx;
        if (dec_valid && dec_branch) begin
            pa = m_anc[$clog2(dec_ctx)];
            m_anc[$clog2(t)] = pa | t;
            m_anc[$clog2(f)] = pa | f;
            m_hot = t;
            m_last = f;
            m_pend |= t | f;
        end
        // a jump into a path squashed in the same cycle is lost
        if (ex_jump_valid) m_pend |= ex_jump_ctx & ~sq;
        exp_valid = (m_pend & m_hot) != '0;
        if (fetch_ctx != m_hot) fail_value("fetch_ctx", fetch_ctx, m_hot);
        if (fetch_valid != exp_valid) fail_value("fetch_valid", fetch_valid, exp_valid);
        if (exp_valid && fetch_ready) m_pend &= ~m_hot;
    endtask

    initial begin
        void'($urandom(32'hd52c_32b9));
        rst_n = 1'b0;
        {cfg_valid, fetch_ready, dec_valid, dec_branch} = '0;
        {ex_jump_valid, ex_branch_valid, ex_hazard} = '0;
        cfg_addr = '0;
        {cfg_wdata, dec_next_pc, dec_next_pc_f, ex_next_pc} = '0;
        {dec_ctx, ex_jump_ctx, ex_branch_ctx, ex_hazard_ctx, ex_safe_ctx} = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        repeat (4) @(posedge clk);
        write_cfg(1'b0, 32'h0000_2a40);
        write_cfg(1'b1, 32'h1);
        write_cfg(1'b1, 32'h3);
        repeat (6) @(posedge clk);
        m_hot = ctx0_mask;
        m_last = ctx0_mask;
        m_pend = ctx0_mask;
        for (int i = 0; i < num_ctx; i++) m_anc[i] = (i == 0) ? ctx0_mask : '0;
        repeat (traffic_cycles) begin
            @(posedge clk);
            drive_random();
            @(negedge clk);
            check_and_update();
        end
        @(posedge clk);
        clear_events();
        repeat (2) @(posedge clk);
        if (i_ctx_frontend_top.i_frontend_assert.fail_cnt == 0) begin
            $display("Test passed");
            $finish;
        end else begin
            $display("Test failed");
            $fatal(1);
        end
    end

endmodule

//--- ctx_frontend_assert.sv
`timescale 1ns/1ns

module ctx_frontend_assert (
    input logic               clk,
    input logic               rst_n,
    input logic               restart,
    input logic               cfg_valid,
    input logic               cfg_ready,
    input ctx_pkg::cfg_addr_t cfg_addr,
    input ctx_pkg::word_t     cfg_wdata,
    input logic               fetch_valid,
    input logic               fetch_ready,
    input ctx_pkg::word_t     fetch_pc,
    input ctx_pkg::ctx_mask_t fetch_ctx,
    input logic               dec_valid,
    input logic               dec_branch,
    input ctx_pkg::ctx_mask_t dec_ctx,
    input ctx_pkg::word_t     dec_next_pc,
    input ctx_pkg::ctx_mask_t dec_ctx_t,
    input ctx_pkg::ctx_mask_t dec_ctx_f,
    input logic               ex_jump_valid,
    input logic               ex_branch_valid,
    input logic               ex_hazard,
    input ctx_pkg::ctx_mask_t ex_hazard_ctx,
    input ctx_pkg::ctx_mask_t hazard_info
);
    import ctx_pkg::*;

    int    fail_cnt = 0;
    logic  idle;
    logic  quiet;
    logic  restart_wr;
    logic  exp_run;
    word_t exp_boot_pc;

    // no decode or exec event in this cycle
    assign idle  = !dec_valid && !ex_jump_valid && !ex_branch_valid && !ex_hazard;
    assign quiet = idle && !restart;

    assign restart_wr = cfg_valid && cfg_ready && cfg_addr == 1'b1 && cfg_wdata[1];

    // register values as written through the config port
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            exp_run     <= 1'b0;
            exp_boot_pc <= boot_pc_reset;
        end else if (cfg_valid && cfg_ready) begin
            if (cfg_addr == 1'b0) begin
                exp_boot_pc <= cfg_wdata;
            end else begin
                exp_run <= cfg_wdata[0];
            end
        end
    end

    function automatic ctx_mask_t rot_two(input ctx_mask_t m);
        return (m << 2) | (m >> (num_ctx - 2));
    endfunction

    a_idle_when_stopped: assert property (@(posedge clk) disable iff (!rst_n)
        !exp_run |-> !fetch_valid)
        else begin
            $error("fetch_valid high while run is low");
            fail_cnt++;
        end

    a_cfg_ready: assert property (@(posedge clk) disable iff (!rst_n)
        cfg_ready == !$past(restart_wr))
        else begin
            $error("Error cfg_ready %h expected %h", cfg_ready, !cfg_ready);
            fail_cnt++;
        end

    a_restart_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        restart_wr && cfg_wdata[0] ##2 idle
        |-> fetch_valid && fetch_ctx == ctx0_mask && fetch_pc == exp_boot_pc)
        else begin
            $error("Error restart fetch_valid %h fetch_ctx %h fetch_pc %h expected %h",
                fetch_valid, fetch_ctx, fetch_pc, exp_boot_pc);
            fail_cnt++;
        end

    a_hold: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && !fetch_ready && !restart ##1 quiet |-> $stable(fetch_pc) && $stable(fetch_ctx))
        else begin
            $error("Error fetch_pc %h changed under back-pressure", fetch_pc);
            fail_cnt++;
        end

    a_accept_drop: assert property (@(posedge clk) disable iff (!rst_n)
        fetch_valid && fetch_ready ##1 quiet |-> !fetch_valid)
        else begin
            $error("fetch_valid still high after accept");
            fail_cnt++;
        end

    a_dec_hot: assert property (@(posedge clk) disable iff (!rst_n)
        exp_run && !restart && dec_valid && !dec_branch && dec_ctx == fetch_ctx
        |-> fetch_valid && fetch_pc == dec_next_pc)
        else begin
            $error("Error fetch_pc %h dec_next_pc %h", fetch_pc, dec_next_pc);
            fail_cnt++;
        end

    a_alloc_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot(dec_ctx_t) && $onehot(dec_ctx_f) && dec_ctx_t != dec_ctx_f)
        else begin
            $error("Error dec_ctx_t %h dec_ctx_f %h", dec_ctx_t, dec_ctx_f);
            fail_cnt++;
        end

    a_branch_fetch: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && dec_branch |-> fetch_ctx == dec_ctx_t && fetch_pc == dec_next_pc)
        else begin
            $error("Error fetch_ctx %h dec_ctx_t %h", fetch_ctx, dec_ctx_t);
            fail_cnt++;
        end

    a_rotate: assert property (@(posedge clk) disable iff (!rst_n)
        dec_valid && dec_branch && !restart |=> dec_ctx_t == rot_two($past(dec_ctx_t)))
        else begin
            $error("Error dec_ctx_t %h did not advance", dec_ctx_t);
            fail_cnt++;
        end

    a_hazard_self: assert property (@(posedge clk) disable iff (!rst_n)
        ex_hazard |-> (hazard_info & ex_hazard_ctx) != '0)
        else begin
            $error("Error hazard_info %h ex_hazard_ctx %h", hazard_info, ex_hazard_ctx);
            fail_cnt++;
        end

endmodule

bind ctx_frontend_top ctx_frontend_assert i_frontend_assert (.*);

//--- ctx_frontend_top.sv
`timescale 1ns/1ns

module ctx_frontend_top #(
    parameter int num_contexts = 8
) (
    input  logic               clk,
    input  logic               rst_n,

    // configuration write port
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  ctx_pkg::cfg_addr_t cfg_addr,
    input  ctx_pkg::word_t     cfg_wdata,

    // fetch request
    output logic               fetch_valid,
    input  logic               fetch_ready,
    output ctx_pkg::word_t     fetch_pc,
    output ctx_pkg::ctx_mask_t fetch_ctx,

    // decode
    input  logic               dec_valid,
    input  logic               dec_branch,
    input  ctx_pkg::ctx_mask_t dec_ctx,
    input  ctx_pkg::word_t     dec_next_pc,
    input  ctx_pkg::word_t     dec_next_pc_f,
    output ctx_pkg::ctx_mask_t dec_ctx_t,
    output ctx_pkg::ctx_mask_t dec_ctx_f,

    // execute
    input  logic               ex_jump_valid,
    input  ctx_pkg::ctx_mask_t ex_jump_ctx,
    input  ctx_pkg::word_t     ex_next_pc,
    input  logic               ex_branch_valid,
    input  ctx_pkg::ctx_mask_t ex_branch_ctx,
    input  logic               ex_hazard,
    input  ctx_pkg::ctx_mask_t ex_hazard_ctx,
    input  ctx_pkg::ctx_mask_t ex_safe_ctx,
    output ctx_pkg::ctx_mask_t hazard_info
);
    import ctx_pkg::*;

    word_t boot_pc;
    logic  run;
    logic  restart;

    ctx_cfg_regs i_ctx_cfg_regs (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_valid (cfg_valid),
        .cfg_ready (cfg_ready),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .boot_pc   (boot_pc),
        .run       (run),
        .restart   (restart)
    );

    context_manage #(
        .num_contexts (num_contexts)
    ) i_context_manage (
        .clk             (clk),
        .rst_n           (rst_n),
        .run             (run),
        .boot_pc         (boot_pc),
        .restart         (restart),
        .fetch_valid     (fetch_valid),
        .fetch_ready     (fetch_ready),
        .fetch_pc        (fetch_pc),
        .fetch_ctx       (fetch_ctx),
        .dec_valid       (dec_valid),
        .dec_branch      (dec_branch),
        .dec_ctx         (dec_ctx),
        .dec_next_pc     (dec_next_pc),
        .dec_next_pc_f   (dec_next_pc_f),
        .dec_ctx_t       (dec_ctx_t),
        .dec_ctx_f       (dec_ctx_f),
        .ex_jump_valid   (ex_jump_valid),
        .ex_jump_ctx     (ex_jump_ctx),
        .ex_next_pc      (ex_next_pc),
        .ex_branch_valid (ex_branch_valid),
        .ex_branch_ctx   (ex_branch_ctx),
        .ex_hazard       (ex_hazard),
        .ex_hazard_ctx   (ex_hazard_ctx),
        .ex_safe_ctx     (ex_safe_ctx),
        .hazard_info     (hazard_info)
    );

endmodule

//--- context_manage.sv
`timescale 1ns/1ns

module context_manage #(
    parameter int num_contexts = 8
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               run,
    input  ctx_pkg::word_t     boot_pc,
    input  logic               restart,

    output logic               fetch_valid,
    input  logic               fetch_ready,
    output ctx_pkg::word_t     fetch_pc,
    output ctx_pkg::ctx_mask_t fetch_ctx,

    input  logic               dec_valid,
    input  logic               dec_branch,
    input  ctx_pkg::ctx_mask_t dec_ctx,
    input  ctx_pkg::word_t     dec_next_pc,
    input  ctx_pkg::word_t     dec_next_pc_f,
    output ctx_pkg::ctx_mask_t dec_ctx_t,
    output ctx_pkg::ctx_mask_t dec_ctx_f,

    input  logic               ex_jump_valid,
    input  ctx_pkg::ctx_mask_t ex_jump_ctx,
    input  ctx_pkg::word_t     ex_next_pc,
    input  logic               ex_branch_valid,
    input  ctx_pkg::ctx_mask_t ex_branch_ctx,
    input  logic               ex_hazard,
    input  ctx_pkg::ctx_mask_t ex_hazard_ctx,
    input  ctx_pkg::ctx_mask_t ex_safe_ctx,
    output ctx_pkg::ctx_mask_t hazard_info
);
    import ctx_pkg::*;

    // context table
    ctx_mask_t hot_q;
    ctx_mask_t last_pub_q;
    ctx_mask_t pend_q;
    ctx_mask_t anc_q [num_contexts];
    word_t     pc_q  [num_contexts];

    ctx_id_t   hot_id;
    ctx_id_t   haz_id;
    ctx_id_t   dec_id;
    ctx_id_t   hot_nxt_id;

    // after branch resolve and squash
    ctx_mask_t res_mask;
    ctx_mask_t squashed;
    ctx_mask_t pend_sq;
    ctx_mask_t hot_sq;
    ctx_mask_t anc_res [num_contexts];
    ctx_mask_t anc_sq  [num_contexts];

    // after decode and jump writes
    logic      dec_wr;
    logic      dec_br;
    ctx_mask_t alloc_hit;
    ctx_mask_t jump_hit;
    ctx_mask_t pend_nxt;
    ctx_mask_t hot_nxt;
    ctx_mask_t last_pub_nxt;
    ctx_mask_t anc_nxt [num_contexts];
    word_t     pc_nxt  [num_contexts];

    logic      fetch_accept;
    ctx_mask_t pend_d;

    assign hot_id = onehot_to_id(hot_q);
    assign haz_id = onehot_to_id(ex_hazard_ctx);
    assign dec_id = onehot_to_id(dec_ctx);

    // next two contexts handed to a branch, rotating
    assign dec_ctx_t = {last_pub_q[num_contexts-2:0], last_pub_q[num_contexts-1]};
    assign dec_ctx_f = {last_pub_q[num_contexts-3:0], last_pub_q[num_contexts-1:num_contexts-2]};

    // everything to discard if the hazard context was wrong
    assign hazard_info = anc_q[haz_id];

    always_comb begin
        res_mask = ex_branch_valid ? ex_branch_ctx : '0;
        squashed = '0;
        pend_sq  = '0;
        for (int i = 0; i < num_contexts; i++) begin
            // resolved branch no longer a reason to squash
            anc_res[i]  = anc_q[i] & ~res_mask;
            squashed[i] = ex_hazard && ((hazard_info & anc_res[i]) != '0);
            anc_sq[i]   = squashed[i] ? '0 : anc_res[i];
            pend_sq[i]  = pend_q[i] && !squashed[i];
        end
        hot_sq = squashed[hot_id] ? ex_safe_ctx : hot_q;
    end

    assign dec_wr = dec_valid && !dec_branch;
    assign dec_br = dec_valid && dec_branch;

    assign alloc_hit = dec_br ? (dec_ctx_t | dec_ctx_f) : '0;
    // jumps into squashed paths are dropped
    assign jump_hit  = ex_jump_valid ? (ex_jump_ctx & ~squashed) : '0;

    always_comb begin
        for (int i = 0; i < num_contexts; i++) begin
            // pc write priority: decode, taken, not-taken, jump
            if (dec_wr && dec_ctx[i]) begin
                pc_nxt[i] = dec_next_pc;
            end else if (alloc_hit[i] && dec_ctx_t[i]) begin
                pc_nxt[i] = dec_next_pc;
            end else if (alloc_hit[i]) begin
                pc_nxt[i] = dec_next_pc_f;
            end else if (jump_hit[i]) begin
                pc_nxt[i] = ex_next_pc;
            end else begin
                pc_nxt[i] = pc_q[i];
            end

            // new context inherits the parent ancestry plus itself
            if (alloc_hit[i]) begin
                anc_nxt[i] = anc_sq[dec_id] | (ctx_mask_t'(1) << i);
            end else begin
                anc_nxt[i] = anc_sq[i];
            end
        end
    end

    assign pend_nxt     = pend_sq | (dec_wr ? dec_ctx : '0) | alloc_hit | jump_hit;
    assign hot_nxt      = dec_br ? dec_ctx_t : hot_sq;
    assign last_pub_nxt = dec_br ? dec_ctx_f : last_pub_q;

    // fetch sees the updated table in the same cycle
    assign hot_nxt_id  = onehot_to_id(hot_nxt);
    assign fetch_ctx   = hot_nxt;
    assign fetch_pc    = pc_nxt[hot_nxt_id];
    // nothing is offered while the table is rebuilt
    assign fetch_valid = run && !restart && pend_nxt[hot_nxt_id];

    assign fetch_accept = fetch_valid && fetch_ready;
    assign pend_d       = pend_nxt & ~(fetch_accept ? hot_nxt : '0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            hot_q      <= ctx0_mask;
            last_pub_q <= ctx0_mask;
            pend_q     <= '0;
            for (int i = 0; i < num_contexts; i++) begin
                anc_q[i] <= '0;
            end
        end else if (restart) begin
            // restart from context 0 alone
            hot_q      <= ctx0_mask;
            last_pub_q <= ctx0_mask;
            pend_q     <= ctx0_mask;
            for (int i = 0; i < num_contexts; i++) begin
                anc_q[i] <= (i == 0) ? ctx0_mask : '0;
            end
        end else begin
            hot_q      <= hot_nxt;
            last_pub_q <= last_pub_nxt;
            pend_q     <= pend_d;
            for (int i = 0; i < num_contexts; i++) begin
                anc_q[i] <= anc_nxt[i];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (restart) begin
            pc_q[0] <= boot_pc;
        end else begin
            for (int i = 0; i < num_contexts; i++) begin
                pc_q[i] <= pc_nxt[i];
            end
        end
    end

endmodule

//--- ctx_cfg_regs.sv
`timescale 1ns/1ns

module ctx_cfg_regs (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               cfg_valid,
    output logic               cfg_ready,
    input  ctx_pkg::cfg_addr_t cfg_addr,
    input  ctx_pkg::word_t     cfg_wdata,
    output ctx_pkg::word_t     boot_pc,
    output logic               run,
    output logic               restart
);
    import ctx_pkg::*;

    localparam cfg_addr_t addr_boot_pc = 1'b0;
    localparam cfg_addr_t addr_ctrl    = 1'b1;

    // control register bit positions
    localparam int ctrl_run_bit     = 0;
    localparam int ctrl_restart_bit = 1;

    logic cfg_write;
    logic ctrl_write;

    assign cfg_write  = cfg_valid && cfg_ready;
    assign ctrl_write = cfg_write && (cfg_addr == addr_ctrl);

    // no new write while the restart pulse is out
    assign cfg_ready = !restart;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            boot_pc <= boot_pc_reset;
        end else if (cfg_write && (cfg_addr == addr_boot_pc)) begin
            boot_pc <= cfg_wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            run <= 1'b0;
        end else if (ctrl_write) begin
            run <= cfg_wdata[ctrl_run_bit];
        end
    end

    // restart bit is self-clearing, one cycle wide
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            restart <= 1'b0;
        end else begin
            restart <= ctrl_write && cfg_wdata[ctrl_restart_bit];
        end
    end

endmodule

//--- ctx_pkg.sv
package ctx_pkg;

    // machine word and context sizing
    localparam int word_len = 32;
    localparam int num_ctx  = 8;

    typedef logic [word_len-1:0]        word_t;
    typedef logic [num_ctx-1:0]         ctx_mask_t;
    typedef logic [$clog2(num_ctx)-1:0] ctx_id_t;

    // two registers, boot pc at 0 and control at 1
    typedef logic [0:0] cfg_addr_t;

    // first instruction fetched after a restart
    localparam word_t boot_pc_reset = 32'h0000_0100;

    // context 0 as a one-hot mask
    localparam ctx_mask_t ctx0_mask = ctx_mask_t'(1);

    // one-hot mask to binary index, OR of the set positions
    function automatic ctx_id_t onehot_to_id(input ctx_mask_t mask);
        ctx_id_t id;
        id = '0;
        for (int i = 0; i < num_ctx; i++) begin
            if (mask[i]) begin
                id = id | ctx_id_t'(i);
            end
        end
        return id;
    endfunction

endpackage
